// ==== sysctl_cfg_pkg.sv ====
`default_nettype none

package sysctl_cfg_pkg;

	localparam int unsigned DEF_CLK_FREQ = 32'd50_000_000;
	localparam int unsigned DEF_BAUD = 32'd115_200;

	// Block RAM depth in 32-bit words
	localparam int unsigned DEF_BRAM_WORDS = 1536;

	typedef logic [31:0] word_t;
	typedef logic [3:0] strb_t;

endpackage

`default_nettype wire

// ==== sysctl_map_pkg.sv ====
`default_nettype none

package sysctl_map_pkg;

	// Top address nibble selects the region
	typedef logic [3:0] region_t;

	localparam region_t REGION_BRAM = 4'h0;
	localparam region_t REGION_IO = 4'hf;

	// Register offsets within the I/O page
	localparam logic [15:0] IO_UART_DATA = 16'h0000;
	localparam logic [15:0] IO_UART_STAT = 16'h0004;
	localparam logic [15:0] IO_LED = 16'h1000;
	localparam logic [15:0] IO_RTC_SECS = 16'h1100;

	// UART status word
	localparam int STAT_DR_BIT = 0;
	localparam int STAT_TXBUSY_BIT = 1;

	// One bus address, seen as region/offset or as page/register
	typedef union packed {
		struct packed {
			region_t region;
			logic [27:0] offset;
		} rgn;
		struct packed {
			logic [15:0] page;
			logic [15:0] reg_off;
		} io;
	} sysctl_addr_u;

	typedef enum logic [1:0] {
		BRAM = 2'd0,
		IO = 2'd1,
		NONE = 2'd2
	} target_e;

endpackage

`default_nettype wire

// ==== bus_decode.sv ====
`default_nettype none

module bus_decode #(
	parameter int unsigned BRAM_WORDS = sysctl_cfg_pkg::DEF_BRAM_WORDS
) (
	input logic clk,
	input logic resetn,
	input logic mem_valid_i,
	input logic [31:0] mem_addr_i,
	input sysctl_cfg_pkg::word_t mem_wdata_i,
	input sysctl_cfg_pkg::strb_t mem_wstrb_i,
	input logic done_i,
	output logic req_valid_o,
	output sysctl_map_pkg::target_e req_target_o,
	output sysctl_map_pkg::sysctl_addr_u req_addr_o,
	output sysctl_cfg_pkg::word_t req_wdata_o,
	output sysctl_cfg_pkg::strb_t req_wstrb_o
);
	import sysctl_map_pkg::*;

	localparam logic [27:0] BRAM_BYTES = 28'(BRAM_WORDS * 4);

	sysctl_addr_u addr;
	target_e target;
	logic busy;
	logic accept;

	assign addr = mem_addr_i;

	// Busy still set on the done edge, so the held request is not taken twice
	assign accept = mem_valid_i && !busy;

	always_comb begin
		if (addr.rgn.region == REGION_BRAM && addr.rgn.offset < BRAM_BYTES)
			target = BRAM;
		else if (addr.rgn.region == REGION_IO)
			target = IO;
		else
			target = NONE;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_valid_o <= 1'b0;
			busy <= 1'b0;
		end else begin
			req_valid_o <= accept;
			if (accept)
				busy <= 1'b1;
			else if (done_i)
				busy <= 1'b0;
		end
	end

	// Request payload stays put until the next accept
	always_ff @(posedge clk) begin
		if (accept) begin
			req_target_o <= target;
			req_addr_o <= addr;
			req_wdata_o <= mem_wdata_i;
			req_wstrb_o <= mem_wstrb_i;
		end
	end

endmodule

`default_nettype wire

// ==== bram_store.sv ====
`default_nettype none

module bram_store #(
	parameter int unsigned BRAM_WORDS = sysctl_cfg_pkg::DEF_BRAM_WORDS
) (
	input logic clk,
	input logic sel_i,
	input logic [$clog2(BRAM_WORDS)-1:0] word_i,
	input sysctl_cfg_pkg::word_t wdata_i,
	input sysctl_cfg_pkg::strb_t wstrb_i,
	output logic ack_o,
	output sysctl_cfg_pkg::word_t rdata_o
);
	import sysctl_cfg_pkg::*;

	word_t mem [BRAM_WORDS];

	// Ack follows the strobe by one cycle
	always_ff @(posedge clk) begin
		ack_o <= sel_i;
	end

	// Read returns the word as it was before this write
	always_ff @(posedge clk) begin
		if (sel_i) begin
			for (int b = 0; b < 4; b++) begin
				if (wstrb_i[b])
					mem[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
			end
			rdata_o <= mem[word_i];
		end
	end

endmodule

`default_nettype wire

// ==== uart_core.sv ====
`default_nettype none

module uart_core #(
	parameter int unsigned CLKS_PER_BIT =
		sysctl_cfg_pkg::DEF_CLK_FREQ / sysctl_cfg_pkg::DEF_BAUD
) (
	input logic clk,
	input logic resetn,
	input logic tx_start_i,
	input logic [7:0] tx_byte_i,
	input logic rx_i,
	output logic tx_o,
	output logic tx_busy_o,
	output logic rx_done_o,
	output logic [7:0] rx_byte_o
);
	localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(CLKS_PER_BIT / 2);

	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA = 2'd2;
	localparam logic [1:0] RX_STOP = 2'd3;

	logic [9:0] tx_shift;
	logic [CNT_W-1:0] tx_cnt;
	logic [3:0] tx_bits;

	logic [1:0] rx_sync;
	logic [1:0] rx_state;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0] rx_bits;
	logic [7:0] rx_shift;

	// Idle line is the all-ones shift register
	assign tx_o = tx_shift[0];

	// Start, 8 data LSB first, stop
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tx_shift <= '1;
			tx_cnt <= '0;
			tx_bits <= '0;
			tx_busy_o <= 1'b0;
		end else if (!tx_busy_o) begin
			if (tx_start_i) begin
				tx_shift <= {1'b1, tx_byte_i, 1'b0};
				tx_cnt <= BIT_LAST;
				tx_bits <= 4'd9;
				tx_busy_o <= 1'b1;
			end
		end else if (tx_cnt == '0) begin
			tx_cnt <= BIT_LAST;
			tx_shift <= {1'b1, tx_shift[9:1]};
			if (tx_bits == '0)
				tx_busy_o <= 1'b0;
			else
				tx_bits <= tx_bits - 4'd1;
		end else begin
			tx_cnt <= tx_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_sync <= 2'b11;
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bits <= '0;
			rx_done_o <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx_i};
			rx_done_o <= 1'b0;
			case (rx_state)
				RX_IDLE: begin
					if (!rx_sync[1]) begin
						rx_cnt <= BIT_HALF;
						rx_state <= RX_START;
					end
				end
				RX_START: begin
					// Glitch check at the middle of the start bit
					if (rx_cnt != '0)
						rx_cnt <= rx_cnt - 1'b1;
					else if (!rx_sync[1]) begin
						rx_cnt <= BIT_LAST;
						rx_bits <= '0;
						rx_state <= RX_DATA;
					end else
						rx_state <= RX_IDLE;
				end
				RX_DATA: begin
					if (rx_cnt != '0)
						rx_cnt <= rx_cnt - 1'b1;
					else begin
						rx_cnt <= BIT_LAST;
						rx_shift <= {rx_sync[1], rx_shift[7:1]};
						if (rx_bits == 3'd7)
							rx_state <= RX_STOP;
						else
							rx_bits <= rx_bits + 3'd1;
					end
				end
				default: begin
					if (rx_cnt != '0)
						rx_cnt <= rx_cnt - 1'b1;
					else begin
						// Framing error drops the byte
						if (rx_sync[1]) begin
							rx_done_o <= 1'b1;
							rx_byte_o <= rx_shift;
						end
						rx_state <= RX_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== sys_regs.sv ====
`default_nettype none

module sys_regs #(
	parameter int unsigned TICKS_PER_SEC = sysctl_cfg_pkg::DEF_CLK_FREQ,
	parameter int unsigned CLKS_PER_BIT =
		sysctl_cfg_pkg::DEF_CLK_FREQ / sysctl_cfg_pkg::DEF_BAUD
) (
	input logic clk,
	input logic resetn,
	input logic sel_i,
	input sysctl_map_pkg::sysctl_addr_u addr_i,
	input sysctl_cfg_pkg::word_t wdata_i,
	input sysctl_cfg_pkg::strb_t wstrb_i,
	input logic uart_rx_i,
	input logic uart_rts_i,
	output logic ack_o,
	output sysctl_cfg_pkg::word_t rdata_o,
	output logic uart_tx_o,
	output logic uart_cts_o,
	output logic led_o
);
	import sysctl_map_pkg::*;

	localparam logic [31:0] TICK_LAST = 32'(TICKS_PER_SEC - 1);

	logic act;
	logic write;
	logic blocked;
	logic tx_start;
	logic [7:0] tx_byte;
	logic tx_busy;
	logic rx_done;
	logic [7:0] rx_byte;
	logic dr;
	logic txbusy;
	logic [31:0] tick_cnt;
	logic [31:0] secs;

	// A blocked data write keeps retrying until txbusy drops
	assign act = sel_i || blocked;
	assign write = |wstrb_i;

	uart_core #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_core (
		.clk(clk),
		.resetn(resetn),
		.tx_start_i(tx_start),
		.tx_byte_i(tx_byte),
		.rx_i(uart_rx_i),
		.tx_o(uart_tx_o),
		.tx_busy_o(tx_busy),
		.rx_done_o(rx_done),
		.rx_byte_o(rx_byte)
	);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ack_o <= 1'b0;
			blocked <= 1'b0;
			tx_start <= 1'b0;
			dr <= 1'b0;
			txbusy <= 1'b0;
			uart_cts_o <= 1'b0;
			led_o <= 1'b1;
		end else begin
			ack_o <= 1'b0;
			tx_start <= 1'b0;
			if (rx_done) begin
				dr <= 1'b1;
				uart_cts_o <= 1'b1;
			end
			// Peer holds RTS high to keep us busy
			if (!tx_start && !tx_busy && !uart_rts_i)
				txbusy <= 1'b0;
			if (act) begin
				case (addr_i.io.reg_off)
					IO_UART_DATA: begin
						if (write && txbusy)
							blocked <= 1'b1;
						else if (write) begin
							tx_byte <= wdata_i[7:0];
							tx_start <= 1'b1;
							txbusy <= 1'b1;
							blocked <= 1'b0;
							rdata_o <= '0;
							ack_o <= 1'b1;
						end else begin
							rdata_o <= {24'b0, rx_byte};
							dr <= 1'b0;
							uart_cts_o <= 1'b0;
							ack_o <= 1'b1;
						end
					end
					IO_UART_STAT: begin
						rdata_o <= '0;
						rdata_o[STAT_DR_BIT] <= dr;
						rdata_o[STAT_TXBUSY_BIT] <= txbusy;
						ack_o <= 1'b1;
					end
					IO_LED: begin
						// LED pin is active low
						if (write)
							led_o <= ~wdata_i[0];
						rdata_o <= {31'b0, ~led_o};
						ack_o <= 1'b1;
					end
					IO_RTC_SECS: begin
						rdata_o <= secs;
						ack_o <= 1'b1;
					end
					default: begin
						rdata_o <= '0;
						ack_o <= 1'b1;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tick_cnt <= '0;
			secs <= '0;
		end else if (tick_cnt == TICK_LAST) begin
			tick_cnt <= '0;
			secs <= secs + 32'd1;
		end else begin
			tick_cnt <= tick_cnt + 32'd1;
		end
	end

endmodule

`default_nettype wire

// ==== bus_response.sv ====
`default_nettype none

module bus_response (
	input logic clk,
	input logic resetn,
	input logic none_sel_i,
	input logic bram_ack_i,
	input sysctl_cfg_pkg::word_t bram_rdata_i,
	input logic io_ack_i,
	input sysctl_cfg_pkg::word_t io_rdata_i,
	output logic mem_ready_o,
	output sysctl_cfg_pkg::word_t mem_rdata_o,
	output logic done_o
);
	logic none_ack;

	// Unmapped addresses answer like a one-cycle target
	always_ff @(posedge clk) begin
		if (!resetn) begin
			none_ack <= 1'b0;
			mem_ready_o <= 1'b0;
		end else begin
			none_ack <= none_sel_i;
			mem_ready_o <= bram_ack_i || io_ack_i || none_ack;
		end
	end

	always_ff @(posedge clk) begin
		if (bram_ack_i)
			mem_rdata_o <= bram_rdata_i;
		else if (io_ack_i)
			mem_rdata_o <= io_rdata_i;
		else if (none_ack)
			mem_rdata_o <= '0;
	end

	// Decode stage frees up on the ready pulse
	assign done_o = mem_ready_o;

endmodule

`default_nettype wire

// ==== sysctl_top.sv ====
`default_nettype none

module sysctl_top #(
	parameter int unsigned CLK_FREQ = sysctl_cfg_pkg::DEF_CLK_FREQ,
	parameter int unsigned BAUD = sysctl_cfg_pkg::DEF_BAUD,
	parameter int unsigned BRAM_WORDS = sysctl_cfg_pkg::DEF_BRAM_WORDS,
	parameter int unsigned TICKS_PER_SEC = CLK_FREQ
) (
	input logic clk,
	input logic resetn,
	input logic mem_valid_i,
	input logic [31:0] mem_addr_i,
	input sysctl_cfg_pkg::word_t mem_wdata_i,
	input sysctl_cfg_pkg::strb_t mem_wstrb_i,
	output logic mem_ready_o,
	output sysctl_cfg_pkg::word_t mem_rdata_o,
	input logic uart_rx_i,
	input logic uart_rts_i,
	output logic uart_tx_o,
	output logic uart_cts_o,
	output logic led_o
);
	import sysctl_map_pkg::*;
	import sysctl_cfg_pkg::*;

	localparam int unsigned CLKS_PER_BIT = CLK_FREQ / BAUD;
	localparam int unsigned IDX_W = $clog2(BRAM_WORDS);

	logic req_valid;
	target_e req_target;
	sysctl_addr_u req_addr;
	word_t req_wdata;
	strb_t req_wstrb;
	logic bram_sel;
	logic io_sel;
	logic none_sel;
	logic bram_ack;
	word_t bram_rdata;
	logic io_ack;
	word_t io_rdata;
	logic done;

	// One strobe per target
	assign bram_sel = req_valid && (req_target == BRAM);
	assign io_sel = req_valid && (req_target == IO);
	assign none_sel = req_valid && (req_target == NONE);

	bus_decode #(
		.BRAM_WORDS(BRAM_WORDS)
	) u_bus_decode (
		.clk(clk),
		.resetn(resetn),
		.mem_valid_i(mem_valid_i),
		.mem_addr_i(mem_addr_i),
		.mem_wdata_i(mem_wdata_i),
		.mem_wstrb_i(mem_wstrb_i),
		.done_i(done),
		.req_valid_o(req_valid),
		.req_target_o(req_target),
		.req_addr_o(req_addr),
		.req_wdata_o(req_wdata),
		.req_wstrb_o(req_wstrb)
	);

	bram_store #(
		.BRAM_WORDS(BRAM_WORDS)
	) u_bram_store (
		.clk(clk),
		.sel_i(bram_sel),
		.word_i(req_addr[IDX_W+1:2]),
		.wdata_i(req_wdata),
		.wstrb_i(req_wstrb),
		.ack_o(bram_ack),
		.rdata_o(bram_rdata)
	);

	sys_regs #(
		.TICKS_PER_SEC(TICKS_PER_SEC),
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_sys_regs (
		.clk(clk),
		.resetn(resetn),
		.sel_i(io_sel),
		.addr_i(req_addr),
		.wdata_i(req_wdata),
		.wstrb_i(req_wstrb),
		.uart_rx_i(uart_rx_i),
		.uart_rts_i(uart_rts_i),
		.ack_o(io_ack),
		.rdata_o(io_rdata),
		.uart_tx_o(uart_tx_o),
		.uart_cts_o(uart_cts_o),
		.led_o(led_o)
	);

	bus_response u_bus_response (
		.clk(clk),
		.resetn(resetn),
		.none_sel_i(none_sel),
		.bram_ack_i(bram_ack),
		.bram_rdata_i(bram_rdata),
		.io_ack_i(io_ack),
		.io_rdata_i(io_rdata),
		.mem_ready_o(mem_ready_o),
		.mem_rdata_o(mem_rdata_o),
		.done_o(done)
	);

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic resetn_o
);
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// Reset released on a rising edge
	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		resetn_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== sysctl_asserts.sv ====
`default_nettype none

module sysctl_asserts (
	input logic clk,
	input logic resetn,
	input logic mem_valid_i,
	input logic mem_ready_i,
	input logic uart_tx_i,
	input logic uart_cts_i,
	input logic led_i,
	input logic txbusy_i
);
	int fail_count = 0;

	ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready_i |=> !mem_ready_i)
	else begin
		fail_count++;
		$error("mem_ready_o stayed high for more than one cycle");
	end

	ready_with_valid: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready_i |-> mem_valid_i)
	else begin
		fail_count++;
		$error("mem_ready_o rose without mem_valid_i");
	end

	// Outputs one cycle into reset
	reset_values: assert property (@(posedge clk)
		!resetn |=> (!mem_ready_i && !uart_cts_i && led_i && uart_tx_i))
	else begin
		fail_count++;
		$error("outputs not at their reset values");
	end

	tx_idle_high: assert property (@(posedge clk) disable iff (!resetn)
		!txbusy_i |-> uart_tx_i)
	else begin
		fail_count++;
		$error("uart_tx_o low while txbusy is clear");
	end

endmodule

bind sysctl_top sysctl_asserts u_sysctl_asserts (
	.clk(clk),
	.resetn(resetn),
	.mem_valid_i(mem_valid_i),
	.mem_ready_i(mem_ready_o),
	.uart_tx_i(uart_tx_o),
	.uart_cts_i(uart_cts_o),
	.led_i(led_o),
	.txbusy_i(u_sys_regs.txbusy)
);

`default_nettype wire

// ==== tb_sysctl.sv ====
`default_nettype none

module tb_sysctl;
	import sysctl_map_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int CLK_FREQ = 1_000_000;
	localparam int BAUD = 100_000;
	localparam int TICKS_PER_SEC = 200;
	localparam int BRAM_WORDS = 1536;
	localparam int BYTE_CYCLES = 10 * (CLK_FREQ / BAUD);
	localparam int BRAM_ROUNDS = 12;
	localparam int BUS_LIMIT = 3 * BYTE_CYCLES;
	// Rough length of each test in cycles, in test order
	localparam int TEST_CYCLES = 60 + BRAM_ROUNDS * 24 + 4 * BYTE_CYCLES
		+ 5 * BYTE_CYCLES + 4 * TICKS_PER_SEC + 120;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 1000;
	localparam logic [31:0] DATA_ADDR = {16'hf000, IO_UART_DATA};
	localparam logic [31:0] STAT_ADDR = {16'hf000, IO_UART_STAT};
	localparam logic [31:0] LED_ADDR = {16'hf000, IO_LED};
	localparam logic [31:0] RTC_ADDR = {16'hf000, IO_RTC_SECS};

	logic clk;
	logic resetn;
	logic mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0] mem_wstrb;
	logic mem_ready;
	logic [31:0] mem_rdata;
	logic uart_line;
	logic uart_cts;
	logic led;
	logic rts;

	logic [31:0] rng_state = 32'h06d1cf9a;
	logic [31:0] bram_model [int];
	logic led_model;
	logic dr_model;
	logic txbusy_model;
	logic [7:0] rx_model;
	logic [31:0] secs_model;
	string chk_name_q[$];
	logic [31:0] chk_exp_q[$];
	logic [31:0] chk_act_q[$];
	int err_count = 0;
	int check_count = 0;
	int test_base = 0;

	assign rts = 1'b0;

	tb_clkgen #(
		.PERIOD(CLK_PERIOD),
		.RESET_CYCLES(3)
	) u_tb_clkgen (
		.clk_o(clk),
		.resetn_o(resetn)
	);

	sysctl_top #(
		.CLK_FREQ(CLK_FREQ),
		.BAUD(BAUD),
		.BRAM_WORDS(BRAM_WORDS),
		.TICKS_PER_SEC(TICKS_PER_SEC)
	) u_sysctl_top (
		.clk(clk),
		.resetn(resetn),
		.mem_valid_i(mem_valid),
		.mem_addr_i(mem_addr),
		.mem_wdata_i(mem_wdata),
		.mem_wstrb_i(mem_wstrb),
		.mem_ready_o(mem_ready),
		.mem_rdata_o(mem_rdata),
		.uart_rx_i(uart_line),
		.uart_rts_i(rts),
		.uart_tx_o(uart_line),
		.uart_cts_o(uart_cts),
		.led_o(led)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] merged;
		for (int b = 0; b < 4; b++)
			merged[b*8 +: 8] = strb[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
		return merged;
	endfunction

	function automatic logic in_bram(input logic [31:0] addr);
		return addr[31:28] == 4'h0 && addr[27:0] < BRAM_WORDS * 4;
	endfunction

	function automatic void ref_write(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb);
		int idx;
		idx = int'(addr[27:2]);
		if (in_bram(addr))
			bram_model[idx] = merge_bytes(bram_model.exists(idx) ? bram_model[idx] : 'x,
				wdata, strb);
		else if (addr == LED_ADDR)
			led_model = wdata[0];
	endfunction

	// Expected read data from the modelled state
	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		if (in_bram(addr))
			return bram_model[int'(addr[27:2])];
		if (addr[31:28] != 4'hf)
			return 32'h0;
		case (addr[15:0])
			IO_UART_DATA: return {24'h0, rx_model};
			IO_UART_STAT: return {30'h0, txbusy_model, dr_model};
			IO_LED: return {31'h0, led_model};
			IO_RTC_SECS: return secs_model;
			default: return 32'h0;
		endcase
	endfunction

	task automatic compare_values(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			err_count++;
		end
	endtask

	task automatic expect_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		chk_name_q.push_back(name);
		chk_exp_q.push_back(expected);
		chk_act_q.push_back(actual);
	endtask

	// Comparison process
	initial begin
		forever begin
			@(negedge clk);
			while (chk_name_q.size() > 0)
				compare_values(chk_name_q.pop_front(), chk_exp_q.pop_front(),
					chk_act_q.pop_front());
		end
	end

	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, output logic [31:0] rdata, output int cycles);
		logic ready;
		@(posedge clk);
		mem_valid <= 1'b1;
		mem_addr <= addr;
		mem_wdata <= wdata;
		mem_wstrb <= strb;
		cycles = 0;
		ready = 1'b0;
		while (!ready && cycles < BUS_LIMIT) begin
			@(negedge clk);
			ready = mem_ready;
			if (!ready)
				cycles++;
		end
		if (!ready) begin
			$display("No mem_ready_o for access to %h at %0t", addr, $time);
			err_count++;
		end
		rdata = mem_rdata;
		@(posedge clk);
		mem_valid <= 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb);
		logic [31:0] unused;
		int cycles;
		bus_access(addr, wdata, strb, unused, cycles);
		expect_value("mem_ready_o latency", 3, cycles);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
		int cycles;
		bus_access(addr, 32'h0, 4'h0, rdata, cycles);
		expect_value("mem_ready_o latency", 3, cycles);
	endtask

	task automatic wait_for_cts();
		int n;
		n = 0;
		while (!uart_cts && n < 3 * BYTE_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (!uart_cts) begin
			$display("Timed out waiting for uart_cts_o to rise at %0t", $time);
			err_count++;
		end
	endtask

	task automatic wait_txbusy_clear();
		logic [31:0] stat;
		int polls;
		polls = 0;
		stat = 32'h2;
		while (stat[STAT_TXBUSY_BIT] && polls < BYTE_CYCLES) begin
			bus_read(STAT_ADDR, stat);
			polls++;
		end
		if (stat[STAT_TXBUSY_BIT]) begin
			$display("Timed out waiting for txbusy to clear at %0t", $time);
			err_count++;
		end
		txbusy_model = 1'b0;
	endtask

	task automatic finish_test(input string name);
		@(negedge clk);
		@(posedge clk);
		$display("%s: %0d errors", name, err_count - test_base);
		test_base = err_count;
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] strb;
		logic [7:0] byte_a;
		logic [7:0] byte_b;
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		int cycles;
		int assert_fails;

		mem_valid = 1'b0;
		mem_addr = 32'h0;
		mem_wdata = 32'h0;
		mem_wstrb = 4'h0;
		led_model = 1'b0;
		dr_model = 1'b0;
		txbusy_model = 1'b0;
		rx_model = 8'h0;
		secs_model = 32'h0;
		wait (resetn === 1'b1);

		bus_read(STAT_ADDR, rd);
		expect_value("uart status", ref_read(STAT_ADDR), rd);
		bus_read(RTC_ADDR, rd);
		expect_value("rtc_secs", ref_read(RTC_ADDR), rd);
		bus_read(LED_ADDR, rd);
		expect_value("led register", ref_read(LED_ADDR), rd);
		expect_value("led_o", 1, led);
		expect_value("uart_cts_o", 0, uart_cts);
		finish_test("Test 1 reset state");

		for (int i = 0; i < BRAM_ROUNDS; i++) begin
			addr = (next_random() % BRAM_WORDS) * 4;
			wdata = next_random();
			bus_write(addr, wdata, 4'hf);
			ref_write(addr, wdata, 4'hf);
			bus_read(addr, rd);
			expect_value("bram word", ref_read(addr), rd);
			wdata = next_random();
			strb = next_random() & 4'hf;
			if (strb == 4'h0)
				strb = 4'b1001;
			bus_write(addr, wdata, strb);
			ref_write(addr, wdata, strb);
			bus_read(addr, rd);
			expect_value("bram strobed word", ref_read(addr), rd);
		end
		finish_test("Test 2 block RAM");

		byte_a = next_random() & 8'hff;
		bus_write(DATA_ADDR, {24'h0, byte_a}, 4'h1);
		txbusy_model = 1'b1;
		bus_read(STAT_ADDR, rd);
		expect_value("uart status", ref_read(STAT_ADDR), rd);
		wait_for_cts();
		bus_read(STAT_ADDR, rd);
		expect_value("uart status dr", 1, rd[STAT_DR_BIT]);
		rx_model = byte_a;
		bus_read(DATA_ADDR, rd);
		expect_value("uart data", ref_read(DATA_ADDR), rd);
		expect_value("uart_cts_o", 0, uart_cts);
		wait_txbusy_clear();
		bus_read(STAT_ADDR, rd);
		expect_value("uart status", ref_read(STAT_ADDR), rd);
		finish_test("Test 3 UART loopback");

		byte_a = next_random() & 8'hff;
		byte_b = next_random() & 8'hff;
		bus_write(DATA_ADDR, {24'h0, byte_a}, 4'h1);
		bus_access(DATA_ADDR, {24'h0, byte_b}, 4'h1, rd, cycles);
		// Held until the first byte has left the shifter
		expect_value("blocked write waited one byte", 1, cycles > 9 * BYTE_CYCLES / 10);
		wait_for_cts();
		rx_model = byte_a;
		bus_read(DATA_ADDR, rd);
		expect_value("first uart byte", ref_read(DATA_ADDR), rd);
		wait_for_cts();
		rx_model = byte_b;
		bus_read(DATA_ADDR, rd);
		expect_value("second uart byte", ref_read(DATA_ADDR), rd);
		wait_txbusy_clear();
		finish_test("Test 4 blocked UART write");

		bus_write(LED_ADDR, 32'h1, 4'hf);
		ref_write(LED_ADDR, 32'h1, 4'hf);
		bus_read(LED_ADDR, rd);
		expect_value("led register", ref_read(LED_ADDR), rd);
		expect_value("led_o", 0, led);
		bus_write(LED_ADDR, 32'h0, 4'hf);
		ref_write(LED_ADDR, 32'h0, 4'hf);
		bus_read(LED_ADDR, rd);
		expect_value("led register", ref_read(LED_ADDR), rd);
		expect_value("led_o", 1, led);
		bus_read(RTC_ADDR, r0);
		repeat (TICKS_PER_SEC) @(posedge clk);
		bus_read(RTC_ADDR, r1);
		repeat (2 * TICKS_PER_SEC) @(posedge clk);
		bus_read(RTC_ADDR, r2);
		expect_value("rtc_secs not decreasing", 1, r1 >= r0 && r2 >= r1);
		expect_value("rtc_secs advanced by 2", 1, r2 >= r0 + 2);
		addr = 32'h5000_0000 | (next_random() & 32'h0fff_fffc);
		bus_write(addr, next_random(), 4'hf);
		bus_read(addr, rd);
		expect_value("unmapped read", ref_read(addr), rd);
		addr = BRAM_WORDS * 4 + (next_random() & 32'h3fc);
		bus_read(addr, rd);
		expect_value("read beyond bram", ref_read(addr), rd);
		finish_test("Test 5 LED, RTC and unmapped");

		assert_fails = u_sysctl_top.u_sysctl_asserts.fail_count;
		$display("Tests: 5, checks: %0d, errors: %0d, assertion failures: %0d",
			check_count, err_count, assert_fails);
		if (err_count == 0 && assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
sysctl_cfg_pkg.sv
sysctl_map_pkg.sv
bus_decode.sv
bram_store.sv
uart_core.sv
sys_regs.sv
bus_response.sv
sysctl_top.sv
tb_clkgen.sv
sysctl_asserts.sv
tb_sysctl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_sysctl
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS ?= +verilator+error+limit+1000
FAIL_MSG = Result: FAILED
BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
